/* io_map_pkg.sv */
package io_map_pkg;

    localparam int DATA_W = 32;

    // ====================
    // Address map
    // ====================
    localparam logic [DATA_W-1:0] IO_BASE = 32'h7000000;

    localparam logic [DATA_W-1:0] ADDR_TIMER1_VALUE = IO_BASE + 32'h02;
    localparam logic [DATA_W-1:0] ADDR_TIMER1_START = IO_BASE + 32'h03;
    localparam logic [DATA_W-1:0] ADDR_TIMER2_VALUE = IO_BASE + 32'h04;
    localparam logic [DATA_W-1:0] ADDR_TIMER2_START = IO_BASE + 32'h05;
    localparam logic [DATA_W-1:0] ADDR_SPI0_DATA    = IO_BASE + 32'h08;  // Flash 1
    localparam logic [DATA_W-1:0] ADDR_SPI0_CS      = IO_BASE + 32'h09;
    localparam logic [DATA_W-1:0] ADDR_SPI1_DATA    = IO_BASE + 32'h0A;  // Flash 2
    localparam logic [DATA_W-1:0] ADDR_SPI1_CS      = IO_BASE + 32'h0B;
    localparam logic [DATA_W-1:0] ADDR_BOOT_MODE    = IO_BASE + 32'h19;
    localparam logic [DATA_W-1:0] ADDR_MICROS       = IO_BASE + 32'h1A;

    // ====================
    // Access types
    // ====================
    typedef enum logic [2:0] {
        REG_NONE,
        REG_TIMER_VALUE,
        REG_TIMER_START,
        REG_SPI_DATA,
        REG_SPI_CS,
        REG_BOOT_MODE,
        REG_MICROS
    } io_reg_e;

    typedef struct packed {
        logic              valid;
        io_reg_e           kind;
        logic              unit;   // Timer 1/2 or SPI 0/1
        logic              we;
        logic [DATA_W-1:0] data;
    } io_req_t;

    typedef struct packed {
        logic    valid;
        io_reg_e kind;
        logic    unit;
    } io_rsp_t;

endpackage

/* io_dev_pkg.sv */
package io_dev_pkg;

    localparam int SPI_BYTE_W = 8;
    localparam int TIMER_W    = 32;

    typedef struct packed {
        logic               set;       // Store new reload value
        logic               trigger;   // Start countdown
        logic [TIMER_W-1:0] value;
    } timer_cmd_t;

    typedef struct packed {
        logic                  start;
        logic [SPI_BYTE_W-1:0] data;
    } spi_cmd_t;

    typedef struct packed {
        logic                  done;
        logic [SPI_BYTE_W-1:0] data;   // Last byte received
    } spi_rsp_t;

endpackage

/* micros_counter.sv */
module micros_counter #(
    parameter int CLKS_PER_US = 100
)
(
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] micros,
    output logic        tick
);

    localparam int PRE_W = (CLKS_PER_US > 1) ? $clog2(CLKS_PER_US) : 1;

    logic [PRE_W-1:0] prescale;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            prescale <= '0;
            micros   <= '0;
            tick     <= 1'b0;
        end
        else
        begin
            tick <= 1'b0;
            if (prescale == PRE_W'(CLKS_PER_US - 1))
            begin
                prescale <= '0;
                micros   <= micros + 1'b1;   // Wraps
                tick     <= 1'b1;
            end
            else
                prescale <= prescale + 1'b1;
        end
    end

endmodule

/* os_timer.sv */
module os_timer
    import io_dev_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  timer_cmd_t cmd,
    input  logic       tick,
    output logic       interrupt
);

    logic [TIMER_W-1:0] reload;
    logic [TIMER_W-1:0] count;
    logic               running;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reload    <= '0;
            count     <= '0;
            running   <= 1'b0;
            interrupt <= 1'b0;
        end
        else
        begin
            interrupt <= 1'b0;

            if (cmd.set)
                reload <= cmd.value;

            // Zero reload ignores the trigger
            if (cmd.trigger && reload != '0)
            begin
                count   <= reload;
                running <= 1'b1;
            end
            else if (running && tick)
            begin
                count <= count - 1'b1;
                if (count == TIMER_W'(1))
                begin
                    running   <= 1'b0;
                    interrupt <= 1'b1;
                end
            end
        end
    end

endmodule

/* spi_master.sv */
module spi_master
    import io_dev_pkg::*;
#(
    parameter int CLKS_PER_HALF_BIT = 2
)
(
    input  logic     clk,
    input  logic     reset,
    input  spi_cmd_t cmd,
    output spi_rsp_t rsp,
    output logic     spi_clk,
    output logic     spi_mosi,
    input  logic     spi_miso
);

    localparam int EDGES  = 2 * SPI_BYTE_W;
    localparam int EDGE_W = $clog2(EDGES);
    localparam int DIV_W  = (CLKS_PER_HALF_BIT > 1) ? $clog2(CLKS_PER_HALF_BIT) : 1;

    logic                  busy;
    logic [DIV_W-1:0]      div_cnt;
    logic [EDGE_W-1:0]     edge_cnt;
    logic [SPI_BYTE_W-1:0] tx_sr;   // Bits still to send with the next one on top
    logic [SPI_BYTE_W-1:0] rx_sr;
    logic                  half_done;

    assign half_done = (div_cnt == DIV_W'(CLKS_PER_HALF_BIT - 1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy     <= 1'b0;
            div_cnt  <= '0;
            edge_cnt <= '0;
            spi_clk  <= 1'b0;
            spi_mosi <= 1'b0;
            rsp      <= '0;
        end
        else
        begin
            rsp.done <= 1'b0;

            if (!busy)
            begin
                // First bit goes out before the first rising edge
                if (cmd.start)
                begin
                    busy     <= 1'b1;
                    div_cnt  <= '0;
                    edge_cnt <= '0;
                    spi_mosi <= cmd.data[SPI_BYTE_W-1];
                    tx_sr    <= {cmd.data[SPI_BYTE_W-2:0], 1'b0};
                end
            end
            else if (half_done)
            begin
                div_cnt  <= '0;
                spi_clk  <= ~spi_clk;
                edge_cnt <= edge_cnt + 1'b1;

                if (!spi_clk)
                    rx_sr <= {rx_sr[SPI_BYTE_W-2:0], spi_miso};   // Rising edge
                else if (edge_cnt == EDGE_W'(EDGES - 1))
                begin
                    busy     <= 1'b0;
                    spi_mosi <= 1'b0;
                    rsp.done <= 1'b1;
                    rsp.data <= rx_sr;
                end
                else
                begin
                    spi_mosi <= tx_sr[SPI_BYTE_W-1];
                    tx_sr    <= {tx_sr[SPI_BYTE_W-2:0], 1'b0};
                end
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

/* io_decode.sv */
module io_decode
    import io_map_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] data,
    input  logic              we,
    input  logic              busy,
    output io_req_t           req
);

    logic              accept;
    logic              cap_valid;
    logic [DATA_W-1:0] cap_addr;
    logic [DATA_W-1:0] cap_data;
    logic              cap_we;
    io_reg_e           kind;
    logic              unit;

    // One access in flight at a time
    assign accept = start && !busy && !cap_valid && !req.valid;

    always_ff @(posedge clk)
    begin
        if (reset)
            cap_valid <= 1'b0;
        else
            cap_valid <= accept;

        if (accept)
        begin
            cap_addr <= addr;
            cap_data <= data;
            cap_we   <= we;
        end
    end

    always_comb
    begin
        kind = REG_NONE;
        unit = 1'b0;
        case (cap_addr)
            ADDR_TIMER1_VALUE: kind = REG_TIMER_VALUE;
            ADDR_TIMER1_START: kind = REG_TIMER_START;
            ADDR_TIMER2_VALUE:
            begin
                kind = REG_TIMER_VALUE;
                unit = 1'b1;
            end
            ADDR_TIMER2_START:
            begin
                kind = REG_TIMER_START;
                unit = 1'b1;
            end
            ADDR_SPI0_DATA:    kind = REG_SPI_DATA;
            ADDR_SPI0_CS:      kind = REG_SPI_CS;
            ADDR_SPI1_DATA:
            begin
                kind = REG_SPI_DATA;
                unit = 1'b1;
            end
            ADDR_SPI1_CS:
            begin
                kind = REG_SPI_CS;
                unit = 1'b1;
            end
            ADDR_BOOT_MODE:    kind = REG_BOOT_MODE;
            ADDR_MICROS:       kind = REG_MICROS;
            default:           kind = REG_NONE;   // Gaps and past the map
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            req.valid <= 1'b0;
        else
            req.valid <= cap_valid;

        req.kind <= kind;
        req.unit <= unit;
        req.we   <= cap_we;
        req.data <= cap_data;
    end

endmodule

/* io_execute.sv */
module io_execute
    import io_map_pkg::*;
    import io_dev_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  io_req_t    req,
    input  spi_rsp_t   spi0_rsp,
    input  spi_rsp_t   spi1_rsp,
    output timer_cmd_t timer1_cmd,
    output timer_cmd_t timer2_cmd,
    output spi_cmd_t   spi0_cmd,
    output spi_cmd_t   spi1_cmd,
    output logic       spi0_cs,
    output logic       spi1_cs,
    output logic       busy,
    output io_rsp_t    rsp
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT_SPI
    } state_e;

    state_e state;
    logic   accept;
    logic   wr;
    logic   spi_done;

    assign accept   = req.valid && (state == ST_IDLE);
    assign wr       = accept && req.we;
    assign spi_done = rsp.unit ? spi1_rsp.done : spi0_rsp.done;   // Port being waited on
    assign busy     = (state == ST_WAIT_SPI) || rsp.valid;

    // ====================
    // Device commands
    // ====================
    always_comb
    begin
        timer1_cmd       = '0;
        timer2_cmd       = '0;
        spi0_cmd         = '0;
        spi1_cmd         = '0;
        timer1_cmd.value = req.data[TIMER_W-1:0];
        timer2_cmd.value = req.data[TIMER_W-1:0];
        spi0_cmd.data    = req.data[SPI_BYTE_W-1:0];
        spi1_cmd.data    = req.data[SPI_BYTE_W-1:0];

        if (wr)
        begin
            case (req.kind)
                REG_TIMER_VALUE:
                begin
                    timer1_cmd.set = !req.unit;
                    timer2_cmd.set = req.unit;
                end
                REG_TIMER_START:
                begin
                    timer1_cmd.trigger = !req.unit;
                    timer2_cmd.trigger = req.unit;
                end
                REG_SPI_DATA:
                begin
                    spi0_cmd.start = !req.unit;
                    spi1_cmd.start = req.unit;
                end
                default: ;
            endcase
        end
    end

    // ====================
    // FSM and chip selects
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state   <= ST_IDLE;
            spi0_cs <= 1'b1;
            spi1_cs <= 1'b1;
            rsp     <= '0;
        end
        else
        begin
            rsp.valid <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    if (accept)
                    begin
                        rsp.kind <= req.kind;
                        rsp.unit <= req.unit;

                        if (wr && req.kind == REG_SPI_CS)
                        begin
                            if (req.unit)
                                spi1_cs <= req.data[0];
                            else
                                spi0_cs <= req.data[0];
                        end

                        if (wr && req.kind == REG_SPI_DATA)
                            state <= ST_WAIT_SPI;
                        else
                            rsp.valid <= 1'b1;
                    end
                end

                ST_WAIT_SPI:
                begin
                    if (spi_done)
                    begin
                        rsp.valid <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

/* io_result.sv */
module io_result
    import io_map_pkg::*;
    import io_dev_pkg::*;
(
    input  logic              clk,
    input  logic              reset,
    input  io_rsp_t           rsp,
    input  spi_rsp_t          spi0_rsp,
    input  spi_rsp_t          spi1_rsp,
    input  logic              spi0_cs,
    input  logic              spi1_cs,
    input  logic              boot_mode,
    input  logic [DATA_W-1:0] micros,
    output logic [DATA_W-1:0] q,
    output logic              done
);

    logic [DATA_W-1:0] sel;

    always_comb
    begin
        case (rsp.kind)
            REG_SPI_DATA:  sel = DATA_W'(rsp.unit ? spi1_rsp.data : spi0_rsp.data);
            REG_SPI_CS:    sel = DATA_W'(rsp.unit ? spi1_cs : spi0_cs);
            REG_BOOT_MODE: sel = DATA_W'(boot_mode);
            REG_MICROS:    sel = micros;
            default:       sel = '0;   // Timers and unmapped
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            q    <= '0;
            done <= 1'b0;
        end
        else
        begin
            done <= rsp.valid;
            q    <= rsp.valid ? sel : '0;
        end
    end

endmodule

/* io_unit_top.sv */
module io_unit_top
    import io_map_pkg::*;
    import io_dev_pkg::*;
#(
    parameter int CLKS_PER_US            = 100,
    parameter int SPI0_CLKS_PER_HALF_BIT = 2,
    parameter int SPI1_CLKS_PER_HALF_BIT = 4
)
(
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic [DATA_W-1:0] addr,
    input  logic [DATA_W-1:0] data,
    input  logic              we,
    output logic [DATA_W-1:0] q,
    output logic              done,
    input  logic              boot_mode,
    output logic              timer1_int,
    output logic              timer2_int,
    output logic              spi0_clk,
    output logic              spi0_cs,
    output logic              spi0_mosi,
    input  logic              spi0_miso,
    output logic              spi1_clk,
    output logic              spi1_cs,
    output logic              spi1_mosi,
    input  logic              spi1_miso
);

    io_req_t           req;
    io_rsp_t           rsp;
    logic              busy;
    timer_cmd_t        timer1_cmd;
    timer_cmd_t        timer2_cmd;
    spi_cmd_t          spi0_cmd;
    spi_cmd_t          spi1_cmd;
    spi_rsp_t          spi0_rsp;
    spi_rsp_t          spi1_rsp;
    logic [DATA_W-1:0] micros;
    logic              tick;

    // ====================
    // Access pipeline
    // ====================
    io_decode u_decode (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .addr  (addr),
        .data  (data),
        .we    (we),
        .busy  (busy),
        .req   (req)
    );

    io_execute u_execute (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .spi0_rsp   (spi0_rsp),
        .spi1_rsp   (spi1_rsp),
        .timer1_cmd (timer1_cmd),
        .timer2_cmd (timer2_cmd),
        .spi0_cmd   (spi0_cmd),
        .spi1_cmd   (spi1_cmd),
        .spi0_cs    (spi0_cs),
        .spi1_cs    (spi1_cs),
        .busy       (busy),
        .rsp        (rsp)
    );

    io_result u_result (
        .clk       (clk),
        .reset     (reset),
        .rsp       (rsp),
        .spi0_rsp  (spi0_rsp),
        .spi1_rsp  (spi1_rsp),
        .spi0_cs   (spi0_cs),
        .spi1_cs   (spi1_cs),
        .boot_mode (boot_mode),
        .micros    (micros),
        .q         (q),
        .done      (done)
    );

    // ====================
    // Devices
    // ====================
    micros_counter #(
        .CLKS_PER_US (CLKS_PER_US)
    ) u_micros (
        .clk    (clk),
        .reset  (reset),
        .micros (micros),
        .tick   (tick)
    );

    os_timer u_timer1 (
        .clk       (clk),
        .reset     (reset),
        .cmd       (timer1_cmd),
        .tick      (tick),
        .interrupt (timer1_int)
    );

    os_timer u_timer2 (
        .clk       (clk),
        .reset     (reset),
        .cmd       (timer2_cmd),
        .tick      (tick),
        .interrupt (timer2_int)
    );

    spi_master #(
        .CLKS_PER_HALF_BIT (SPI0_CLKS_PER_HALF_BIT)
    ) u_spi0 (
        .clk      (clk),
        .reset    (reset),
        .cmd      (spi0_cmd),
        .rsp      (spi0_rsp),
        .spi_clk  (spi0_clk),
        .spi_mosi (spi0_mosi),
        .spi_miso (spi0_miso)
    );

    spi_master #(
        .CLKS_PER_HALF_BIT (SPI1_CLKS_PER_HALF_BIT)
    ) u_spi1 (
        .clk      (clk),
        .reset    (reset),
        .cmd      (spi1_cmd),
        .rsp      (spi1_rsp),
        .spi_clk  (spi1_clk),
        .spi_mosi (spi1_mosi),
        .spi_miso (spi1_miso)
    );

endmodule

/* tb_io_unit.sv */
module tb_io_unit;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLKS_PER_US   = 10;
    localparam int FIELDS        = 6;
    localparam int MAX_LINES     = 40;
    localparam int FIXED_LATENCY = 3;
    localparam int SPI_TIMEOUT   = 300;
    localparam int SPI_BITS      = 8;     // Rising SPI clock edges per byte
    localparam int TRIGGER_EDGE  = 2;     // Timer write lands at edge 2
    localparam int MICROS_GAP    = 237;
    localparam logic [31:0] END_KIND = 32'hF;

    localparam logic [31:0] IO_BASE           = 32'h0700_0000;
    localparam logic [31:0] ADDR_TIMER1_VALUE = IO_BASE + 32'h02;
    localparam logic [31:0] ADDR_TIMER1_START = IO_BASE + 32'h03;
    localparam logic [31:0] ADDR_TIMER2_VALUE = IO_BASE + 32'h04;
    localparam logic [31:0] ADDR_TIMER2_START = IO_BASE + 32'h05;
    localparam logic [31:0] ADDR_SPI1_DATA    = IO_BASE + 32'h0A;
    localparam logic [31:0] ADDR_SPI1_CS      = IO_BASE + 32'h0B;
    localparam logic [31:0] ADDR_MICROS       = IO_BASE + 32'h1A;

    logic        clk;
    logic        reset;
    logic        start;
    logic [31:0] addr;
    logic [31:0] data;
    logic        we;
    logic        boot_mode;
    logic [31:0] q;
    logic        done;
    logic        timer1_int;
    logic        timer2_int;
    logic        spi0_clk;
    logic        spi0_cs;
    logic        spi0_mosi;
    logic        spi1_clk;
    logic        spi1_cs;
    logic        spi1_mosi;

    logic [31:0] golden [0:FIELDS*MAX_LINES-1];
    int          error_count;
    int          timeout_count;
    int          cycle_count;
    int          spi0_edges;
    int          spi1_edges;

    // Loopback on both ports
    io_unit_top #(
        .CLKS_PER_US (CLKS_PER_US)
    ) DUT (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .addr       (addr),
        .data       (data),
        .we         (we),
        .q          (q),
        .done       (done),
        .boot_mode  (boot_mode),
        .timer1_int (timer1_int),
        .timer2_int (timer2_int),
        .spi0_clk   (spi0_clk),
        .spi0_cs    (spi0_cs),
        .spi0_mosi  (spi0_mosi),
        .spi0_miso  (spi0_mosi),
        .spi1_clk   (spi1_clk),
        .spi1_cs    (spi1_cs),
        .spi1_mosi  (spi1_mosi),
        .spi1_miso  (spi1_mosi)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
        cycle_count <= cycle_count + 1;

    always @(posedge spi0_clk)
        spi0_edges++;

    always @(posedge spi1_clk)
        spi1_edges++;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAILED %s: got %h, expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // ====================
    // CPU access
    // ====================
    // Called on a falling edge; returns one cycle after done
    task automatic run_access(input logic [31:0] a, input logic [31:0] d, input logic w,
                              input logic b, input bit wait_spi, output logic [31:0] result);
        int lat;
        int limit;
        limit     = wait_spi ? SPI_TIMEOUT : FIXED_LATENCY + 5;
        addr      = a;
        data      = d;
        we        = w;
        boot_mode = b;
        start     = 1'b1;
        lat       = -1;   // Edge 0 is the first one counted
        result    = '0;
        do
        begin
            @(negedge clk);
            start = 1'b0;
            lat++;
        end
        while (!done && lat < limit);
        if (!done)
        begin
            $display("Timeout: no done within %0d cycles for address %h", limit, a);
            timeout_count++;
        end
        else
        begin
            result = q;
            if (!wait_spi)
                check_value("done_latency", 32'(lat), 32'(FIXED_LATENCY));
        end
        @(negedge clk);
        check_value("done", 32'(done), 32'h0);   // One-cycle pulse
        check_value("q", q, 32'h0);
    endtask

    task automatic run_golden();
        int          line;
        int          base;
        int          e0;
        int          e1;
        int          spi0_exp;
        int          spi1_exp;
        logic [31:0] kind;
        logic [31:0] result;
        line = 0;
        while (line < MAX_LINES)
        begin
            base = line * FIELDS;
            kind = golden[base];
            if (kind == END_KIND)
                break;
            if (kind > 32'd2)
            begin
                $display("Unknown access kind %h in golden line %0d", kind, line);
                error_count++;
                break;
            end
            e0 = spi0_edges;
            e1 = spi1_edges;
            run_access(golden[base+1], golden[base+2], golden[base+3][0],
                       golden[base+4][0], kind == 32'd1, result);
            check_value("q", result, golden[base+5]);
            if (kind == 32'd2)
            begin
                if (golden[base+1] == ADDR_SPI1_CS)
                    check_value("spi1_cs", 32'(spi1_cs), golden[base+5]);
                else
                    check_value("spi0_cs", 32'(spi0_cs), golden[base+5]);
            end

            // Only an SPI data write clocks its own port
            spi0_exp = 0;
            spi1_exp = 0;
            if (kind == 32'd1)
            begin
                if (golden[base+1] == ADDR_SPI1_DATA)
                    spi1_exp = SPI_BITS;
                else
                    spi0_exp = SPI_BITS;
            end
            check_value("spi0_clk_edges", 32'(spi0_edges - e0), 32'(spi0_exp));
            check_value("spi1_clk_edges", 32'(spi1_edges - e1), 32'(spi1_exp));
            line++;
        end
        if (line == 0)
        begin
            $display("No accesses were read from io_golden.txt");
            error_count++;
        end
    endtask

    // ====================
    // Counter and timers
    // ====================
    task automatic test_micros();
        int          c1;
        int          c2;
        int          expect_us;
        int          diff;
        logic [31:0] m1;
        logic [31:0] m2;
        c1 = cycle_count;
        run_access(ADDR_MICROS, 32'h0, 1'b0, 1'b0, 1'b0, m1);
        for (int n = 0; n < MICROS_GAP; n++)
            @(negedge clk);
        c2 = cycle_count;
        run_access(ADDR_MICROS, 32'h0, 1'b0, 1'b0, 1'b0, m2);
        expect_us = (c2 - c1) / CLKS_PER_US;
        diff      = int'(m2 - m1);
        if (m2 <= m1)
        begin
            $display("Micros count did not increase: %h then %h", m1, m2);
            error_count++;
        end
        else if (diff > expect_us + 1 || diff < expect_us - 1)
        begin
            $display("Micros advanced by %0d, expected %0d within one", diff, expect_us);
            error_count++;
        end
    endtask

    task automatic test_timer(input bit unit, input int n);
        int          c0;
        int          waited;
        int          offset;
        int          limit;
        bit          fired;
        bit          other_seen;
        logic [31:0] result;
        limit      = (n + 2) * CLKS_PER_US;
        fired      = 1'b0;
        other_seen = 1'b0;
        waited     = 0;
        run_access(unit ? ADDR_TIMER2_VALUE : ADDR_TIMER1_VALUE, 32'(n), 1'b1, 1'b0, 1'b0,
                   result);
        c0 = cycle_count;
        run_access(unit ? ADDR_TIMER2_START : ADDR_TIMER1_START, 32'h0, 1'b1, 1'b0, 1'b0,
                   result);
        while (!fired && waited < limit)
        begin
            @(negedge clk);
            waited++;
            if (unit ? timer2_int : timer1_int)
                fired = 1'b1;
            if (unit ? timer1_int : timer2_int)
                other_seen = 1'b1;
        end
        if (!fired)
        begin
            $display("Timeout: timer %0d interrupt did not fire", unit + 1);
            timeout_count++;
        end
        else
        begin
            offset = cycle_count - c0 - (TRIGGER_EDGE + 1);
            if (offset < (n - 1) * CLKS_PER_US || offset > n * CLKS_PER_US)
            begin
                $display("Timer %0d fired %0d cycles after trigger, outside %0d us window",
                         unit + 1, offset, n);
                error_count++;
            end
        end
        if (other_seen)
        begin
            $display("Timer %0d interrupt pulsed during the timer %0d test", 2 - unit, unit + 1);
            error_count++;
        end
    endtask

    initial
    begin
        clk           = 1'b0;
        reset         = 1'b1;
        start         = 1'b0;
        addr          = '0;
        data          = '0;
        we            = 1'b0;
        boot_mode     = 1'b0;
        error_count   = 0;
        timeout_count = 0;
        cycle_count   = 0;
        spi0_edges    = 0;
        spi1_edges    = 0;
        $readmemh("io_golden.txt", golden);

        for (int n = 0; n < 10; n++)
            @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_value("done", 32'(done), 32'h0);
        check_value("q", q, 32'h0);
        check_value("spi0_clk", 32'(spi0_clk), 32'h0);
        check_value("spi1_clk", 32'(spi1_clk), 32'h0);
        check_value("spi0_mosi", 32'(spi0_mosi), 32'h0);
        check_value("spi1_mosi", 32'(spi1_mosi), 32'h0);
        check_value("spi0_cs", 32'(spi0_cs), 32'h1);
        check_value("spi1_cs", 32'(spi1_cs), 32'h1);
        check_value("timer1_int", 32'(timer1_int), 32'h0);
        check_value("timer2_int", 32'(timer2_int), 32'h0);

        run_golden();
        test_micros();
        // Timer 1 keeps a shorter reload than the timer 2 run
        test_timer(1'b0, 5);
        test_timer(1'b1, 7);

        $display("Errors: %0d check failures, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* io_golden.txt */
// kind addr data we boot_mode expected_q
// kind 0 fixed latency, 1 SPI data write, 2 chip select write checked on pin, F ends
0 07000000 00000000 0 0 00000000
0 07000001 DEADBEEF 1 1 00000000
0 07000006 00000000 0 0 00000000
0 0700000C 00000055 1 0 00000000
0 07000018 00000000 0 1 00000000
0 07000040 00000000 0 0 00000000
0 00000000 00000000 0 0 00000000
0 07000002 00000007 1 0 00000000
0 07000005 00000001 1 0 00000000
0 07000009 00000000 0 0 00000001
0 0700000B 00000000 0 0 00000001
2 07000009 00000000 1 0 00000000
2 0700000B 00000000 1 0 00000000
2 07000009 FFFFFFFF 1 0 00000001
2 0700000B 00000001 1 0 00000001
1 07000008 123456A5 1 0 000000A5
0 07000008 00000000 0 0 000000A5
1 0700000A FFFFFF3C 1 0 0000003C
0 0700000A 00000000 0 0 0000003C
0 07000019 00000000 0 1 00000001
0 07000019 00000000 0 0 00000000
F 00000000 00000000 0 0 00000000

/* project.f */
io_map_pkg.sv
io_dev_pkg.sv
micros_counter.sv
os_timer.sv
spi_master.sv
io_decode.sv
io_execute.sv
io_result.sv
io_unit_top.sv
tb_io_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the IO unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_io_unit \
    -f project.f --Mdir obj_dir -o sim_io_unit

./obj_dir/sim_io_unit > sim.log
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    echo "Simulation passed"
    exit 0
fi
echo "Simulation failed"
exit 1
